/* verilog/phold_pkg.sv */
package phold_pkg;

   localparam int NUM_CORE    = 4;
   localparam int NB_COREID   = 2;
   localparam int NB_LPID     = 6;
   localparam int TIME_WID    = 16;
   localparam int QUEUE_DEPTH = 16;
   localparam int NB_QCNT     = 5;
   localparam int NB_RAND     = 16;
   localparam int CNT_WID     = 32;

   localparam logic [NB_RAND-1:0] LFSR_SEED = 16'hace1;

   typedef struct packed {
      logic [NB_LPID-1:0]  lp;
      logic [TIME_WID-1:0] ts;
   } event_t;

   // event plus the random word drawn when it left the queue
   typedef struct packed {
      event_t             ev;
      logic [NB_RAND-1:0] rnd;
   } dispatch_t;

   typedef struct packed {
      logic                busy;
      logic [TIME_WID-1:0] ts;
   } core_status_t;

   typedef enum logic [1:0] {
      IDLE,
      INIT,
      RUNNING,
      FINISHED
   } sim_state_e;

   typedef enum logic [1:0] {
      CORE_IDLE,
      CORE_EXEC,
      CORE_SEND
   } core_state_e;

   // first requester at or after ptr, wrapping around
   function automatic logic [NB_COREID-1:0] rr_pick(
      input logic [NUM_CORE-1:0]  req,
      input logic [NB_COREID-1:0] ptr
   );
      logic [NB_COREID-1:0] idx;
      logic [NB_COREID-1:0] pick;
      logic                 found;
      pick  = ptr;
      found = 1'b0;
      for (int k = 0; k < NUM_CORE; k++) begin
         idx = ptr + NB_COREID'(k);
         if (!found && req[idx]) begin
            pick  = idx;
            found = 1'b1;
         end
      end
      return pick;
   endfunction

endpackage

/* verilog/event_queue.sv */
module event_queue (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           enq,
   input  phold_pkg::event_t              enq_event,
   input  logic                           deq,
   output phold_pkg::event_t              head,
   output logic                           empty,
   output logic                           full,
   output logic [phold_pkg::NB_QCNT-1:0]  count
);
   import phold_pkg::*;

   event_t                 entry [QUEUE_DEPTH];
   logic [QUEUE_DEPTH-1:0] stay;

   // valid entries with ts not above the new one keep their slot
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         stay[i] = (i < count) && (entry[i].ts <= enq_event.ts);
      end
   end

   // sorted insert or shift toward the head
   always_ff @(posedge clk) begin
      if (enq) begin
         if (!stay[0]) begin
            entry[0] <= enq_event;
         end
         for (int i = 1; i < QUEUE_DEPTH; i++) begin
            if (!stay[i]) begin
               if (stay[i-1]) begin
                  entry[i] <= enq_event;
               end else begin
                  entry[i] <= entry[i-1];
               end
            end
         end
      end else if (deq) begin
         for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
            entry[i] <= entry[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (enq) begin
         count <= count + 1'b1;
      end else if (deq) begin
         count <= count - 1'b1;
      end
   end

   assign head  = entry[0];
   assign empty = (count == '0);
   assign full  = (count == NB_QCNT'(QUEUE_DEPTH));

   assert property (@(posedge clk) disable iff (!rst_n) !(enq && full))
      else $error("enqueue into a full queue");
   assert property (@(posedge clk) disable iff (!rst_n) !(deq && empty))
      else $error("dequeue from an empty queue");
   assert property (@(posedge clk) disable iff (!rst_n) !(enq && deq))
      else $error("enqueue and dequeue in the same cycle");

endmodule

/* verilog/event_dispatch.sv */
module event_dispatch (
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  logic                                                 run,
   input  phold_pkg::event_t                                    head,
   input  logic                                                 empty,
   input  logic                                                 enq,
   input  logic [phold_pkg::NB_RAND-1:0]                        rnd,
   input  phold_pkg::core_status_t [phold_pkg::NUM_CORE-1:0]    status,
   output logic                                                 deq,
   output phold_pkg::dispatch_t                                 dispatch,
   output logic [phold_pkg::NUM_CORE-1:0]                       dispatch_sel
);
   import phold_pkg::*;

   logic [NUM_CORE-1:0]  idle;
   logic [NB_COREID-1:0] ptr;
   logic [NB_COREID-1:0] pick;

   always_comb begin
      for (int i = 0; i < NUM_CORE; i++) begin
         idle[i] = !status[i].busy;
      end
   end

   assign pick = rr_pick(idle, ptr);

   // enqueue owns the queue when both want it
   assign deq          = run && !empty && !enq && (|idle);
   assign dispatch_sel = deq ? ({{(NUM_CORE-1){1'b0}}, 1'b1} << pick) : '0;
   assign dispatch     = '{ev: head, rnd: rnd};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (deq) begin
         ptr <= pick + 1'b1;
      end
   end

   // at most one core leaves idle on each edge
   assert property (@(posedge clk) disable iff (!rst_n) $onehot0($past(idle) & ~idle))
      else $error("more than one core selected");
   assert property (@(posedge clk) disable iff (!rst_n) (dispatch_sel & ~idle) == '0)
      else $error("event dispatched to a busy core");

endmodule

/* verilog/phold_core.sv */
module phold_core (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            sel,
   input  phold_pkg::dispatch_t            dispatch,
   input  logic [phold_pkg::NB_LPID-1:0]   lp_mask,
   output phold_pkg::core_status_t         status,
   output logic                            new_vld,
   output phold_pkg::event_t               new_event,
   input  logic                            ack
);
   import phold_pkg::*;

   core_state_e         state;
   logic [1:0]          delay;
   logic [TIME_WID-1:0] cur_ts;
   event_t              succ;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= CORE_IDLE;
         delay <= '0;
      end else begin
         case (state)
            CORE_IDLE: begin
               if (sel) begin
                  state <= CORE_EXEC;
                  delay <= dispatch.rnd[11:10];
               end
            end
            // stays here delay+1 cycles
            CORE_EXEC: begin
               if (delay == '0) begin
                  state <= CORE_SEND;
               end else begin
                  delay <= delay - 1'b1;
               end
            end
            CORE_SEND: begin
               if (ack) begin
                  state <= CORE_IDLE;
               end
            end
            default: state <= CORE_IDLE;
         endcase
      end
   end

   // successor: random target LP, strictly later time
   always_ff @(posedge clk) begin
      if (sel && state == CORE_IDLE) begin
         cur_ts  <= dispatch.ev.ts;
         succ.lp <= dispatch.rnd[5:0] & lp_mask;
         succ.ts <= dispatch.ev.ts + TIME_WID'(1) + TIME_WID'(dispatch.rnd[9:6]);
      end
   end

   assign status    = '{busy: state != CORE_IDLE, ts: cur_ts};
   assign new_vld   = (state == CORE_SEND);
   assign new_event = succ;

endmodule

/* verilog/event_collect.sv */
module event_collect (
   input  logic                                           clk,
   input  logic                                           rst_n,
   input  logic                                           init_vld,
   input  phold_pkg::event_t                              init_event,
   input  logic [phold_pkg::NUM_CORE-1:0]                 new_vld,
   input  phold_pkg::event_t [phold_pkg::NUM_CORE-1:0]    new_event,
   input  logic                                           full,
   output logic [phold_pkg::NUM_CORE-1:0]                 ack,
   output logic                                           enq,
   output phold_pkg::event_t                              enq_event
);
   import phold_pkg::*;

   logic [NB_COREID-1:0] ptr;
   logic [NB_COREID-1:0] pick;
   logic                 grant;

   assign pick = rr_pick(new_vld, ptr);

   // initial events first, cores only while there is room
   assign grant     = !init_vld && !full && (|new_vld);
   assign enq       = init_vld || grant;
   assign enq_event = init_vld ? init_event : new_event[pick];
   assign ack       = grant ? ({{(NUM_CORE-1){1'b0}}, 1'b1} << pick) : '0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (grant) begin
         ptr <= pick + 1'b1;
      end
   end

   // at most one core's offer taken on each edge
   assert property (@(posedge clk) disable iff (!rst_n) $onehot0($past(new_vld) & ~new_vld))
      else $error("more than one core acknowledged");

endmodule

/* verilog/sim_control.sv */
module sim_control (
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  logic                                                 start,
   input  logic [phold_pkg::NB_QCNT-1:0]                        num_init_events,
   input  logic [phold_pkg::TIME_WID-1:0]                       sim_end,
   input  logic [phold_pkg::NB_LPID-1:0]                        lp_mask,
   input  logic                                                 deq,
   input  phold_pkg::event_t                                    head,
   input  logic                                                 empty,
   input  phold_pkg::core_status_t [phold_pkg::NUM_CORE-1:0]    status,
   output logic                                                 run,
   output logic [phold_pkg::NB_RAND-1:0]                        rnd,
   output logic                                                 init_vld,
   output phold_pkg::event_t                                    init_event,
   output logic [phold_pkg::TIME_WID-1:0]                       gvt,
   output logic                                                 rtn_vld,
   output logic [phold_pkg::CNT_WID-1:0]                        total_cycles,
   output logic [phold_pkg::CNT_WID-1:0]                        total_events
);
   import phold_pkg::*;

   sim_state_e          state;
   logic [NB_QCNT-1:0]  init_cnt;
   logic [NB_RAND-1:0]  lfsr;
   logic [TIME_WID-1:0] min_ts;
   logic                min_vld;
   logic                past_end;

   assign past_end = (gvt > sim_end);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= IDLE;
         init_cnt <= '0;
         rtn_vld  <= 1'b0;
      end else begin
         rtn_vld <= (state == RUNNING) && past_end;
         case (state)
            IDLE: begin
               init_cnt <= '0;
               if (start) begin
                  state <= INIT;
               end
            end
            INIT: begin
               init_cnt <= init_cnt + 1'b1;
               if (init_cnt == num_init_events - 1'b1) begin
                  state <= RUNNING;
               end
            end
            RUNNING: begin
               if (past_end) begin
                  state <= FINISHED;
               end
            end
            // held here until reset
            default: state <= FINISHED;
         endcase
      end
   end

   assign run        = (state == RUNNING);
   assign init_vld   = (state == INIT);
   assign init_event = '{lp: NB_LPID'(init_cnt) & lp_mask, ts: '0};

   // x^16 + x^14 + x^13 + x^11 + 1, one step per dispatched event
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lfsr <= LFSR_SEED;
      end else if (deq) begin
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      end
   end

   assign rnd = lfsr;

   // earliest time still pending, queue head or any busy core
   always_comb begin
      min_vld = !empty;
      min_ts  = head.ts;
      for (int i = 0; i < NUM_CORE; i++) begin
         if (status[i].busy && (!min_vld || status[i].ts < min_ts)) begin
            min_ts  = status[i].ts;
            min_vld = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt          <= '0;
         total_cycles <= '0;
         total_events <= '0;
      end else begin
         if (run && min_vld) begin
            gvt <= min_ts;
         end
         if (run) begin
            total_cycles <= total_cycles + 1'b1;
         end
         if (deq) begin
            total_events <= total_events + 1'b1;
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) gvt >= $past(gvt))
      else $error("gvt moved backwards");

endmodule

/* verilog/phold_top.sv */
module phold_top (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             start,
   input  logic [phold_pkg::NB_QCNT-1:0]    num_init_events,
   input  logic [phold_pkg::TIME_WID-1:0]   sim_end,
   input  logic [phold_pkg::NB_LPID-1:0]    lp_mask,
   output logic [phold_pkg::TIME_WID-1:0]   gvt,
   output logic                             rtn_vld,
   output logic                             evt_vld,
   output phold_pkg::event_t                evt,
   output logic [phold_pkg::CNT_WID-1:0]    total_cycles,
   output logic [phold_pkg::CNT_WID-1:0]    total_events
);
   import phold_pkg::*;

   logic                          run;
   logic [NB_RAND-1:0]            rnd;
   logic                          init_vld;
   event_t                        init_event;
   logic                          enq;
   event_t                        enq_event;
   logic                          deq;
   event_t                        head;
   logic                          empty;
   logic                          full;
   dispatch_t                     dispatch;
   logic [NUM_CORE-1:0]           dispatch_sel;
   core_status_t [NUM_CORE-1:0]   status;
   logic [NUM_CORE-1:0]           new_vld;
   event_t [NUM_CORE-1:0]         new_event;
   logic [NUM_CORE-1:0]           ack;

   sim_control u_sim_control (
      .clk             (clk),
      .rst_n           (rst_n),
      .start           (start),
      .num_init_events (num_init_events),
      .sim_end         (sim_end),
      .lp_mask         (lp_mask),
      .deq             (deq),
      .head            (head),
      .empty           (empty),
      .status          (status),
      .run             (run),
      .rnd             (rnd),
      .init_vld        (init_vld),
      .init_event      (init_event),
      .gvt             (gvt),
      .rtn_vld         (rtn_vld),
      .total_cycles    (total_cycles),
      .total_events    (total_events)
   );

   event_queue u_event_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .enq       (enq),
      .enq_event (enq_event),
      .deq       (deq),
      .head      (head),
      .empty     (empty),
      .full      (full),
      .count     ()
   );

   event_dispatch u_event_dispatch (
      .clk          (clk),
      .rst_n        (rst_n),
      .run          (run),
      .head         (head),
      .empty        (empty),
      .enq          (enq),
      .rnd          (rnd),
      .status       (status),
      .deq          (deq),
      .dispatch     (dispatch),
      .dispatch_sel (dispatch_sel)
   );

   event_collect u_event_collect (
      .clk        (clk),
      .rst_n      (rst_n),
      .init_vld   (init_vld),
      .init_event (init_event),
      .new_vld    (new_vld),
      .new_event  (new_event),
      .full       (full),
      .ack        (ack),
      .enq        (enq),
      .enq_event  (enq_event)
   );

   for (genvar g = 0; g < NUM_CORE; g++) begin : gen_core
      phold_core u_phold_core (
         .clk       (clk),
         .rst_n     (rst_n),
         .sel       (dispatch_sel[g]),
         .dispatch  (dispatch),
         .lp_mask   (lp_mask),
         .status    (status[g]),
         .new_vld   (new_vld[g]),
         .new_event (new_event[g]),
         .ack       (ack[g])
      );
   end

   // dispatch stream seen from outside
   assign evt_vld = deq;
   assign evt     = head;

endmodule

/* verif/phold_tb.sv */
module phold_tb;
   import phold_pkg::*;

   localparam int CLK_PERIOD  = 20;
   localparam int PASS_CYCLES = 3000;
   localparam int NUM_PASSES  = 3;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                start;
   logic [NB_QCNT-1:0]  num_init_events;
   logic [TIME_WID-1:0] sim_end;
   logic [NB_LPID-1:0]  lp_mask;
   logic [TIME_WID-1:0] gvt;
   logic                rtn_vld;
   logic                evt_vld;
   event_t              evt;
   logic [CNT_WID-1:0]  total_cycles;
   logic [CNT_WID-1:0]  total_events;

   // checker state, cleared in reset
   int                  errors;
   int                  checked_events;
   bit                  started;
   bit                  rtn_seen;
   int                  since_start;
   int                  n_init;
   int                  ev_count;
   int                  exp_cycles;
   int                  lp_left [64];
   logic [TIME_WID-1:0] prev_gvt;
   logic [TIME_WID-1:0] frozen_gvt;
   logic [CNT_WID-1:0]  frozen_cycles;

   phold_top uut (
      .clk             (clk),
      .rst_n           (rst_n),
      .start           (start),
      .num_init_events (num_init_events),
      .sim_end         (sim_end),
      .lp_mask         (lp_mask),
      .gvt             (gvt),
      .rtn_vld         (rtn_vld),
      .evt_vld         (evt_vld),
      .evt             (evt),
      .total_cycles    (total_cycles),
      .total_events    (total_events)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic log_error(input string msg);
      errors++;
      $display("error at %0t: %s", $time, msg);
   endtask

   // output checks on every falling edge
   always @(negedge clk) begin
      if (!rst_n) begin
         started     = 0;
         rtn_seen    = 0;
         since_start = 0;
         ev_count    = 0;
         prev_gvt    = '0;
         for (int i = 0; i < 64; i++) begin
            lp_left[i] = 0;
         end
         assert (!rtn_vld && !evt_vld && gvt == '0 && total_cycles == '0 && total_events == '0)
            else log_error("outputs not cleared during reset");
      end else begin
         if (started) begin
            since_start++;
         end
         if (!started) begin
            assert (!rtn_vld && !evt_vld && gvt == '0 && total_cycles == '0 && total_events == '0)
               else log_error("outputs active before start");
         end
         assert (total_events == CNT_WID'(ev_count))
            else log_error("total_events differs from dispatched count");
         assert (gvt >= prev_gvt) else log_error("gvt decreased");
         if (started && !rtn_seen) begin
            exp_cycles = (since_start > n_init + 1) ? since_start - n_init - 1 : 0;
            assert (total_cycles == CNT_WID'(exp_cycles))
               else log_error("total_cycles off its one-per-cycle count");
            assert (rtn_vld == (prev_gvt > sim_end))
               else log_error("rtn_vld not in the cycle after gvt passed sim_end");
         end
         if (rtn_seen) begin
            assert (!rtn_vld) else log_error("rtn_vld high for more than one cycle");
            assert (!evt_vld) else log_error("event dispatched after finish");
            assert (gvt == frozen_gvt) else log_error("gvt changed after finish");
            assert (total_cycles == frozen_cycles)
               else log_error("total_cycles changed after finish");
         end
         if (evt_vld) begin
            checked_events++;
            assert ((evt.lp & ~lp_mask) == '0) else log_error("event lp outside lp_mask");
            assert (evt.ts >= gvt) else log_error("event time below gvt");
            if (ev_count < n_init) begin
               assert (evt.ts == '0) else log_error("initial event time not zero");
               assert (lp_left[evt.lp] > 0) else log_error("initial event lp not expected");
               if (lp_left[evt.lp] > 0) begin
                  lp_left[evt.lp]--;
               end
            end else begin
               assert (evt.ts >= 1) else log_error("successor event time zero");
            end
            ev_count++;
         end
         if (rtn_vld && !rtn_seen) begin
            rtn_seen      = 1;
            frozen_gvt    = gvt;
            frozen_cycles = total_cycles;
         end
         // expected initial LPs, index masked
         if (start && !started) begin
            started     = 1;
            since_start = 0;
            n_init      = int'(num_init_events);
            for (int i = 0; i < n_init; i++) begin
               lp_left[NB_LPID'(i) & lp_mask]++;
            end
         end
         prev_gvt = gvt;
      end
   end

   task automatic run_pass(input logic [NB_QCNT-1:0] n, input logic [NB_LPID-1:0] mask,
                           input logic [TIME_WID-1:0] end_time);
      @(posedge clk);
      rst_n           <= 1'b0;
      num_init_events <= n;
      lp_mask         <= mask;
      sim_end         <= end_time;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (4) @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      do begin
         @(negedge clk);
      end while (!rtn_vld);
      // keep watching the frozen outputs for a while
      repeat (40) @(posedge clk);
   endtask

   initial begin
      #(NUM_PASSES * PASS_CYCLES * CLK_PERIOD);
      $display("run stopped by the watchdog, a pass never finished (%0d errors)", errors);
      $display("Checks failed");
      $finish;
   end

   initial begin
      rst_n           = 1'b0;
      start           = 1'b0;
      num_init_events = '0;
      sim_end         = '0;
      lp_mask         = '0;
      errors          = 0;
      checked_events  = 0;
      run_pass(5'd16, 6'h3f, 16'd200);
      run_pass(5'd5, 6'h0f, 16'd100);
      run_pass(5'd1, 6'h21, 16'd50);
      $display("errors: %0d, dispatched events checked: %0d", errors, checked_events);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* vlog.f */
verilog/phold_pkg.sv
verilog/event_queue.sv
verilog/event_dispatch.sv
verilog/phold_core.sv
verilog/event_collect.sv
verilog/sim_control.sv
verilog/phold_top.sv
verif/phold_tb.sv
